// ==== ls_config.svh ====
`ifndef LS_CONFIG_SVH
`define LS_CONFIG_SVH

// queue slots and index width
`define LS_DEPTH 16
`define LS_SLOT_W 4

// data and address width
`define LS_XLEN 32

// reorder buffer tag width where id 0 is no tag
`define LS_ROB_W 5

`endif

// ==== ls_pkg.sv ====
`default_nettype none

`include "ls_config.svh"

package ls_pkg;

  // everything above LHU is a store
  typedef enum logic [2:0] {
    LB, LH, LW, LBU, LHU, SB, SH, SW
  } ls_op_e;

  typedef logic [`LS_ROB_W-1:0] rob_id_t;
  typedef logic [`LS_XLEN-1:0] word_t;

  typedef struct packed {
    ls_op_e  op;
    rob_id_t qj;
    rob_id_t qk;
    // vj holds the base, then the computed address
    word_t   vj;
    word_t   vk;
    word_t   imm;
    logic    addr_done;
    logic    committed;
    logic    busy;
    rob_id_t dest;
  } ls_entry_t;

endpackage

`default_nettype wire

// ==== ls_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// head of the queue towards the memory sequencer
interface head_if
  import ls_pkg::*;
();
  logic    ready;
  ls_op_e  op;
  word_t   addr;
  word_t   data;
  rob_id_t dest;
  logic    pop;

  modport producer (
    output ready,
    output op,
    output addr,
    output data,
    output dest,
    input  pop
  );

  modport consumer (
    input  ready,
    input  op,
    input  addr,
    input  data,
    input  dest,
    output pop
  );
endinterface

// raw load data towards the writeback stage
interface wb_if
  import ls_pkg::*;
();
  logic       valid;
  ls_op_e     op;
  logic [1:0] addr_lo;
  word_t      rdata;
  rob_id_t    dest;

  modport source (
    output valid,
    output op,
    output addr_lo,
    output rdata,
    output dest
  );

  modport sink (
    input valid,
    input op,
    input addr_lo,
    input rdata,
    input dest
  );
endinterface

`default_nettype wire

// ==== ls_entry_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ls_config.svh"

module ls_entry_queue
  import ls_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    reset_from_rob_bus,
  input  wire rob_id_t dest_from_issuer,
  input  wire ls_op_e  op_from_issuer,
  input  wire rob_id_t qj_from_issuer,
  input  wire rob_id_t qk_from_issuer,
  input  wire word_t   vj_from_issuer,
  input  wire word_t   vk_from_issuer,
  input  wire word_t   imm_from_issuer,
  input  wire rob_id_t dest_from_rss_bus,
  input  wire word_t   value_from_rss_bus,
  input  wire rob_id_t dest_from_lsb_bus,
  input  wire word_t   value_from_lsb_bus,
  input  wire rob_id_t dest_from_rob_bus,
  output logic         ls_buffer_full,
  head_if.producer     head
);

  ls_entry_t entries [`LS_DEPTH];

  logic [`LS_SLOT_W-1:0] head_ptr;
  logic [`LS_SLOT_W-1:0] tail_ptr;
  logic [`LS_SLOT_W:0]   count;
  logic [`LS_SLOT_W:0]   count_next;
  logic                  issue;
  logic                  calc_found;
  logic [`LS_SLOT_W-1:0] calc_slot;
  ls_entry_t             head_entry;
  ls_entry_t             new_entry;

  assign issue = (dest_from_issuer != '0) && !ls_buffer_full;

  always_comb begin
    count_next = count;
    if (issue && !head.pop) begin
      count_next = count + 1'b1;
    end else if (!issue && head.pop) begin
      count_next = count - 1'b1;
    end
  end

  // lowest eligible slot wins the adder
  always_comb begin
    calc_found = 1'b0;
    calc_slot  = '0;
    for (int i = `LS_DEPTH - 1; i >= 0; i--) begin
      if (entries[i].busy && !entries[i].addr_done && entries[i].qj == '0) begin
        calc_found = 1'b1;
        calc_slot  = i[`LS_SLOT_W-1:0];
      end
    end
  end

  // new entry with operands caught from this cycle's broadcasts
  always_comb begin
    new_entry.op  = op_from_issuer;
    new_entry.qj  = qj_from_issuer;
    new_entry.vj  = vj_from_issuer;
    new_entry.qk  = qk_from_issuer;
    new_entry.vk  = vk_from_issuer;
    if (qj_from_issuer != '0 && qj_from_issuer == dest_from_rss_bus) begin
      new_entry.qj = '0;
      new_entry.vj = value_from_rss_bus;
    end else if (qj_from_issuer != '0 && qj_from_issuer == dest_from_lsb_bus) begin
      new_entry.qj = '0;
      new_entry.vj = value_from_lsb_bus;
    end
    if (qk_from_issuer != '0 && qk_from_issuer == dest_from_rss_bus) begin
      new_entry.qk = '0;
      new_entry.vk = value_from_rss_bus;
    end else if (qk_from_issuer != '0 && qk_from_issuer == dest_from_lsb_bus) begin
      new_entry.qk = '0;
      new_entry.vk = value_from_lsb_bus;
    end
    new_entry.imm       = imm_from_issuer;
    new_entry.addr_done = 1'b0;
    new_entry.committed = 1'b0;
    new_entry.busy      = 1'b1;
    new_entry.dest      = dest_from_issuer;
  end

  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      head_ptr       <= '0;
      tail_ptr       <= '0;
      count          <= '0;
      ls_buffer_full <= 1'b0;
      for (int i = 0; i < `LS_DEPTH; i++) begin
        entries[i].busy <= 1'b0;
      end
    end else begin
      for (int i = 0; i < `LS_DEPTH; i++) begin
        if (entries[i].busy) begin
          if (dest_from_rss_bus != '0 && entries[i].qj == dest_from_rss_bus) begin
            entries[i].qj <= '0;
            entries[i].vj <= value_from_rss_bus;
          end
          if (dest_from_lsb_bus != '0 && entries[i].qj == dest_from_lsb_bus) begin
            entries[i].qj <= '0;
            entries[i].vj <= value_from_lsb_bus;
          end
          if (dest_from_rss_bus != '0 && entries[i].qk == dest_from_rss_bus) begin
            entries[i].qk <= '0;
            entries[i].vk <= value_from_rss_bus;
          end
          if (dest_from_lsb_bus != '0 && entries[i].qk == dest_from_lsb_bus) begin
            entries[i].qk <= '0;
            entries[i].vk <= value_from_lsb_bus;
          end
          if (dest_from_rob_bus != '0 && entries[i].dest == dest_from_rob_bus) begin
            entries[i].committed <= 1'b1;
          end
        end
      end

      if (calc_found) begin
        entries[calc_slot].vj        <= entries[calc_slot].vj + entries[calc_slot].imm;
        entries[calc_slot].addr_done <= 1'b1;
      end

      if (head.pop) begin
        entries[head_ptr].busy <= 1'b0;
        head_ptr               <= head_ptr + 1'b1;
      end

      if (issue) begin
        entries[tail_ptr] <= new_entry;
        tail_ptr          <= tail_ptr + 1'b1;
      end

      count <= count_next;
      // one slot of slack for the issuer
      ls_buffer_full <= count_next >= (`LS_DEPTH - 1);
    end
  end

  assign head_entry = entries[head_ptr];

  // stores wait for the rob commit
  assign head.ready = head_entry.busy && head_entry.qj == '0 && head_entry.qk == '0 &&
                      head_entry.addr_done && (head_entry.op <= LHU || head_entry.committed);
  assign head.op    = head_entry.op;
  assign head.addr  = head_entry.vj;
  assign head.data  = head_entry.vk;
  assign head.dest  = head_entry.dest;

endmodule

`default_nettype wire

// ==== ls_mem_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ls_config.svh"

module ls_mem_sequencer
  import ls_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   reset_from_rob_bus,
  head_if.consumer    head,
  output logic        mem_req,
  output logic        mem_we,
  output word_t       mem_addr,
  output word_t       mem_wdata,
  output logic [3:0]  mem_wstrb,
  input  wire logic   mem_ack,
  input  wire word_t  mem_rdata,
  wb_if.source        wb
);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    RELEASE
  } seq_state_e;

  seq_state_e state;
  logic       pop_q;
  logic       valid_q;
  ls_op_e     op_q;
  logic [1:0] lo_q;
  rob_id_t    dest_q;
  word_t      rdata_q;
  logic [1:0] byte_off;
  logic [3:0] strb;
  word_t      lane_data;

  assign byte_off  = head.addr[1:0];
  assign lane_data = head.data << {byte_off, 3'b000};

  always_comb begin
    case (head.op)
      SB:      strb = 4'b0001 << byte_off;
      SH:      strb = 4'b0011 << byte_off;
      SW:      strb = 4'b1111;
      default: strb = 4'b0000;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      state   <= IDLE;
      mem_req <= 1'b0;
      pop_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      pop_q   <= 1'b0;
      valid_q <= 1'b0;
      case (state)
        IDLE: begin
          // the old head is still visible while pop is high
          if (head.ready && !pop_q && !mem_ack) begin
            mem_req <= 1'b1;
            state   <= REQ;
          end
        end
        REQ: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            state   <= RELEASE;
          end
        end
        RELEASE: begin
          if (!mem_ack) begin
            pop_q   <= 1'b1;
            valid_q <= !mem_we;
            state   <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // request fields stay stable from the edge that raises mem_req
  always_ff @(posedge clk) begin
    if (state == IDLE) begin
      mem_addr  <= {head.addr[`LS_XLEN-1:2], 2'b00};
      mem_we    <= head.op > LHU;
      mem_wstrb <= strb;
      mem_wdata <= lane_data;
      op_q      <= head.op;
      lo_q      <= byte_off;
      dest_q    <= head.dest;
    end
    if (state == REQ && mem_ack) begin
      rdata_q <= mem_rdata;
    end
  end

  assign head.pop   = pop_q;
  assign wb.valid   = valid_q;
  assign wb.op      = op_q;
  assign wb.addr_lo = lo_q;
  assign wb.rdata   = rdata_q;
  assign wb.dest    = dest_q;

endmodule

`default_nettype wire

// ==== ls_load_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ls_config.svh"

module ls_load_writeback
  import ls_pkg::*;
(
  input  wire logic clk,
  input  wire logic reset_from_rob_bus,
  wb_if.sink        wb,
  output rob_id_t   dest_to_lsb_bus,
  output word_t     value_to_lsb_bus
);

  word_t shifted;
  word_t extended;

  // bring the addressed byte or half down to bit 0
  assign shifted = wb.rdata >> {wb.addr_lo, 3'b000};

  always_comb begin
    case (wb.op)
      LB:      extended = {{(`LS_XLEN - 8){shifted[7]}}, shifted[7:0]};
      LH:      extended = {{(`LS_XLEN - 16){shifted[15]}}, shifted[15:0]};
      LBU:     extended = {{(`LS_XLEN - 8){1'b0}}, shifted[7:0]};
      LHU:     extended = {{(`LS_XLEN - 16){1'b0}}, shifted[15:0]};
      default: extended = wb.rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      dest_to_lsb_bus  <= '0;
      value_to_lsb_bus <= '0;
    end else if (wb.valid) begin
      dest_to_lsb_bus  <= wb.dest;
      value_to_lsb_bus <= extended;
    end else begin
      dest_to_lsb_bus  <= '0;
      value_to_lsb_bus <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== ls_buffer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ls_buffer_top
  import ls_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    reset_from_rob_bus,
  input  wire rob_id_t dest_from_issuer,
  input  wire ls_op_e  op_from_issuer,
  input  wire rob_id_t qj_from_issuer,
  input  wire rob_id_t qk_from_issuer,
  input  wire word_t   vj_from_issuer,
  input  wire word_t   vk_from_issuer,
  input  wire word_t   imm_from_issuer,
  input  wire rob_id_t dest_from_rss_bus,
  input  wire word_t   value_from_rss_bus,
  input  wire rob_id_t dest_from_rob_bus,
  output logic         ls_buffer_full,
  output logic         mem_req,
  output logic         mem_we,
  output word_t        mem_addr,
  output word_t        mem_wdata,
  output logic [3:0]   mem_wstrb,
  input  wire logic    mem_ack,
  input  wire word_t   mem_rdata,
  output rob_id_t      dest_to_lsb_bus,
  output word_t        value_to_lsb_bus
);

  head_if head_bus ();
  wb_if   wb_bus ();

  ls_entry_queue queue (
    .clk                (clk),
    .reset_from_rob_bus (reset_from_rob_bus),
    .dest_from_issuer   (dest_from_issuer),
    .op_from_issuer     (op_from_issuer),
    .qj_from_issuer     (qj_from_issuer),
    .qk_from_issuer     (qk_from_issuer),
    .vj_from_issuer     (vj_from_issuer),
    .vk_from_issuer     (vk_from_issuer),
    .imm_from_issuer    (imm_from_issuer),
    .dest_from_rss_bus  (dest_from_rss_bus),
    .value_from_rss_bus (value_from_rss_bus),
    // own load results wake dependent entries
    .dest_from_lsb_bus  (dest_to_lsb_bus),
    .value_from_lsb_bus (value_to_lsb_bus),
    .dest_from_rob_bus  (dest_from_rob_bus),
    .ls_buffer_full     (ls_buffer_full),
    .head               (head_bus.producer)
  );

  ls_mem_sequencer sequencer (
    .clk                (clk),
    .reset_from_rob_bus (reset_from_rob_bus),
    .head               (head_bus.consumer),
    .mem_req            (mem_req),
    .mem_we             (mem_we),
    .mem_addr           (mem_addr),
    .mem_wdata          (mem_wdata),
    .mem_wstrb          (mem_wstrb),
    .mem_ack            (mem_ack),
    .mem_rdata          (mem_rdata),
    .wb                 (wb_bus.source)
  );

  ls_load_writeback writeback (
    .clk                (clk),
    .reset_from_rob_bus (reset_from_rob_bus),
    .wb                 (wb_bus.sink),
    .dest_to_lsb_bus    (dest_to_lsb_bus),
    .value_to_lsb_bus   (value_to_lsb_bus)
  );

endmodule

`default_nettype wire

// ==== tb_ls_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ls_buffer
  import ls_pkg::*;
();

  localparam int max_cycles = 4000;

  logic       clk;
  logic       reset_from_rob_bus;
  rob_id_t    dest_from_issuer;
  ls_op_e     op_from_issuer;
  rob_id_t    qj_from_issuer;
  rob_id_t    qk_from_issuer;
  word_t      vj_from_issuer;
  word_t      vk_from_issuer;
  word_t      imm_from_issuer;
  rob_id_t    dest_from_rss_bus;
  word_t      value_from_rss_bus;
  rob_id_t    dest_from_rob_bus;
  logic       ls_buffer_full;
  logic       mem_req;
  logic       mem_we;
  word_t      mem_addr;
  word_t      mem_wdata;
  logic [3:0] mem_wstrb;
  logic       mem_ack;
  word_t      mem_rdata;
  rob_id_t    dest_to_lsb_bus;
  word_t      value_to_lsb_bus;

  word_t   mem [64];
  word_t   shadow [64];
  rob_id_t exp_dest [$];
  word_t   exp_value [$];
  string   exp_name [$];
  int      errors = 0;
  int      checks = 0;
  int      cycles = 0;
  int      ack_wait;
  logic    ack_armed;
  logic    ack_hold;
  integer  seed = 32'h66c;
  rob_id_t tag_ctr;

  ls_buffer_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic word_t fill_word(int i);
    return (i * 32'h9e37_79b9) ^ 32'h5ac3_3c5a;
  endfunction

  // expected load result from the op, byte offset and memory word
  function automatic word_t load_value(ls_op_e op, logic [1:0] offset, word_t word);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[{offset, 3'b000} +: 8];
    h = offset[1] ? word[31:16] : word[15:0];
    case (op)
      LB:      return {{24{b[7]}}, b};
      LH:      return {{16{h[15]}}, h};
      LBU:     return {24'h0, b};
      LHU:     return {16'h0, h};
      default: return word;
    endcase
  endfunction

  task automatic take_tag(output rob_id_t tag);
    tag = tag_ctr;
    // tag 30 stays free for the rss bus
    tag_ctr = (tag_ctr == 5'd29) ? 5'd1 : tag_ctr + 5'd1;
  endtask

  task automatic issue(ls_op_e op, rob_id_t dest, rob_id_t qj, word_t vj, word_t vk,
                       word_t imm);
    while (ls_buffer_full) @(negedge clk);
    op_from_issuer   = op;
    dest_from_issuer = dest;
    qj_from_issuer   = qj;
    qk_from_issuer   = '0;
    vj_from_issuer   = vj;
    vk_from_issuer   = vk;
    imm_from_issuer  = imm;
    @(negedge clk);
    dest_from_issuer = '0;
  endtask

  // base is the value the address operand will finally hold
  task automatic issue_load(ls_op_e op, rob_id_t qj, word_t vj, word_t imm, word_t base,
                            string name, output rob_id_t tag);
    word_t addr;
    take_tag(tag);
    addr = base + imm;
    exp_dest.push_back(tag);
    exp_value.push_back(load_value(op, addr[1:0], shadow[addr[7:2]]));
    exp_name.push_back(name);
    issue(op, tag, qj, vj, '0, imm);
  endtask

  task automatic issue_store(ls_op_e op, word_t addr, word_t data, output rob_id_t tag);
    take_tag(tag);
    case (op)
      SB:      shadow[addr[7:2]][{addr[1:0], 3'b000} +: 8] = data[7:0];
      SH:      shadow[addr[7:2]][{addr[1], 4'b0000} +: 16] = data[15:0];
      default: shadow[addr[7:2]] = data;
    endcase
    issue(op, tag, '0, addr, data, '0);
  endtask

  task automatic commit_store(rob_id_t tag);
    dest_from_rob_bus = tag;
    @(negedge clk);
    dest_from_rob_bus = '0;
  endtask

  task automatic wait_drain();
    while (exp_dest.size() != 0 || mem_req || mem_ack) @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  task automatic load_all_kinds(word_t base);
    rob_id_t tag;
    for (int off = 0; off < 4; off++) begin
      issue_load(LB, '0, base, word_t'(off), base, "lb", tag);
      issue_load(LBU, '0, base, word_t'(off), base, "lbu", tag);
      if (off % 2 == 0) begin
        issue_load(LH, '0, base, word_t'(off), base, "lh", tag);
        issue_load(LHU, '0, base, word_t'(off), base, "lhu", tag);
      end
      if (off == 0) begin
        issue_load(LW, '0, base, '0, base, "lw", tag);
      end
    end
  endtask

  // four-phase memory with a random ack delay
  always @(negedge clk) begin
    if (reset_from_rob_bus) begin
      mem_ack   = 1'b0;
      ack_armed = 1'b0;
    end else if (mem_req && !mem_ack && !ack_hold) begin
      if (!ack_armed) begin
        ack_wait  = $unsigned($random(seed)) % 4;
        ack_armed = 1'b1;
      end
      if (ack_wait == 0) begin
        if (mem_we) begin
          for (int b = 0; b < 4; b++) begin
            if (mem_wstrb[b]) mem[mem_addr[7:2]][b*8 +: 8] = mem_wdata[b*8 +: 8];
          end
        end
        mem_rdata = mem[mem_addr[7:2]];
        mem_ack   = 1'b1;
        ack_armed = 1'b0;
      end else begin
        ack_wait--;
      end
    end else if (!mem_req && mem_ack) begin
      mem_ack = 1'b0;
    end
  end

  // results must come back in issue order
  always @(negedge clk) begin
    if (!reset_from_rob_bus && dest_to_lsb_bus != '0) begin
      if (exp_dest.size() == 0) begin
        $display("result for tag %0d arrived with no load outstanding", dest_to_lsb_bus);
        errors++;
      end else begin
        checks++;
        if (dest_to_lsb_bus != exp_dest[0]) begin
          $display("Mismatch %s dest: expected %0d, actual %0d", exp_name[0], exp_dest[0],
                   dest_to_lsb_bus);
          errors++;
        end
        if (value_to_lsb_bus != exp_value[0]) begin
          $display("Mismatch %s value: expected %h, actual %h", exp_name[0], exp_value[0],
                   value_to_lsb_bus);
          errors++;
        end
        exp_dest.delete(0);
        exp_value.delete(0);
        exp_name.delete(0);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("run did not finish within %0d cycles", max_cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    rob_id_t tag_s;
    rob_id_t tag_a;
    word_t   a_val;
    word_t   base;
    word_t   r;
    ls_op_e  op;
    logic [1:0] off;
    int      accepted;
    reset_from_rob_bus = 1'b1;
    dest_from_issuer   = '0;
    op_from_issuer     = LB;
    qj_from_issuer     = '0;
    qk_from_issuer     = '0;
    vj_from_issuer     = '0;
    vk_from_issuer     = '0;
    imm_from_issuer    = '0;
    dest_from_rss_bus  = '0;
    value_from_rss_bus = '0;
    dest_from_rob_bus  = '0;
    mem_ack            = 1'b0;
    mem_rdata          = '0;
    ack_hold           = 1'b0;
    ack_armed          = 1'b0;
    tag_ctr            = 5'd1;
    for (int i = 0; i < 64; i++) begin
      mem[i]    = fill_word(i);
      shadow[i] = fill_word(i);
    end
    // small pointer word for the dependent load
    mem[5]    = 32'h0000_0040;
    shadow[5] = 32'h0000_0040;
    repeat (5) @(negedge clk);
    reset_from_rob_bus = 1'b0;

    if (dest_to_lsb_bus !== '0 || mem_req !== 1'b0 || ls_buffer_full !== 1'b0) begin
      $display("outputs not idle after reset");
      errors++;
    end

    load_all_kinds(32'h20);
    load_all_kinds(32'h2c);
    wait_drain();

    // store waits for commit, and the load behind it too
    issue_store(SW, 32'h80, 32'hcafe_f00d, tag_s);
    issue_load(LW, '0, 32'h80, '0, 32'h80, "store-load", tag_a);
    repeat (8) begin
      @(negedge clk);
      if (mem_req || dest_to_lsb_bus != '0) begin
        $display("memory request or result seen before the store was committed");
        errors++;
      end
    end
    commit_store(tag_s);
    issue_store(SB, 32'h85, 32'h0000_00a5, tag_s);
    commit_store(tag_s);
    issue_store(SH, 32'h86, 32'h0000_8e21, tag_s);
    commit_store(tag_s);
    issue_load(LB, '0, 32'h84, 32'h1, 32'h84, "sb-lb", tag_a);
    issue_load(LHU, '0, 32'h84, 32'h2, 32'h84, "sh-lhu", tag_a);
    issue_load(LW, '0, 32'h84, '0, 32'h84, "sub-word-lw", tag_a);
    wait_drain();

    // base from the rss bus, then a load fed by the first one
    a_val = load_value(LW, 2'b00, shadow[5]);
    issue_load(LW, 5'd30, '0, 32'h4, 32'h10, "rss-wakeup", tag_a);
    issue_load(LW, tag_a, '0, 32'h8, a_val, "lsb-wakeup", tag_s);
    repeat (4) begin
      @(negedge clk);
      if (mem_req) begin
        $display("memory request seen before the base tag was broadcast");
        errors++;
      end
    end
    dest_from_rss_bus  = 5'd30;
    value_from_rss_bus = 32'h10;
    @(negedge clk);
    dest_from_rss_bus  = '0;
    value_from_rss_bus = '0;
    wait_drain();

    // fill the queue against a stalled memory
    ack_hold = 1'b1;
    accepted = 0;
    while (!ls_buffer_full && accepted < 20) begin
      r    = $random(seed);
      op   = ls_op_e'(accepted % 5);
      base = {24'h0, r[7:2], 2'b00};
      off  = (op == LW) ? 2'b00 : (op == LH || op == LHU) ? {r[9], 1'b0} : r[9:8];
      issue_load(op, '0, base, {30'h0, off}, base, "back-pressure", tag_a);
      accepted++;
    end
    if (accepted != 15) begin
      $display("Mismatch back-pressure count: expected 15, actual %0d", accepted);
      errors++;
    end
    ack_hold = 1'b0;
    wait_drain();

    $display("checked %0d results, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
ls_pkg.sv
ls_if.sv
ls_entry_queue.sv
ls_mem_sequencer.sv
ls_load_writeback.sv
ls_buffer_top.sv
tb_ls_buffer.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then search the log for the pass line
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_ls_buffer -f sim.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -qF "*** TEST PASSED ***" sim.log && exit 0 || exit 1
